//--- kbd_bus_pkg.sv
package kbd_bus_pkg;

	// wishbone classic request, master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr;
		logic [15:0] dat;
	} wb_req_t;

	// wishbone classic response, slave to master
	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// one received frame as stored in the FIFO
	typedef struct packed {
		logic [7:0] code;
		logic       perr;	// bad start, parity or stop bit
	} scan_entry_t;

	// register map
	typedef enum logic [1:0] {
		REG_DATA    = 2'd0,
		REG_STATUS  = 2'd1,
		REG_CONTROL = 2'd2
	} reg_addr_t;

	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_CNT_W = 4;	// holds 0..FIFO_DEPTH
	localparam int FIFO_PTR_W = 3;	// index into FIFO_DEPTH slots

endpackage

//--- kbd_core.sv
`timescale 1ns/100ps

module kbd_core
	import kbd_bus_pkg::*;
(
	input  logic    clock,
	input  logic    reset_i,
	input  logic    ps2_clk_i,
	input  logic    ps2_data_i,
	output logic    ps2_clk_o,
	output logic    ps2_clk_d_o,
	output logic    ps2_data_o,
	output logic    ps2_data_d_o,
	input  wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o
);

	logic                  rx_push;
	scan_entry_t           rx_entry;
	scan_entry_t           fifo_head;
	logic [FIFO_CNT_W-1:0] fifo_count;
	logic                  fifo_full;
	logic                  fifo_empty;
	logic                  fifo_pop;
	logic                  kbd_enable;
	logic                  clk_drive_q;

	ps2_frame_rx rx0 (
		.clock      (clock),
		.reset_i    (reset_i),
		.ps2_clk_i  (ps2_clk_i),
		.ps2_data_i (ps2_data_i),
		.inhibit_i  (clk_drive_q),	// same view as the pad
		.push_o     (rx_push),
		.entry_o    (rx_entry)
	);

	scan_fifo fifo0 (
		.clock   (clock),
		.reset_i (reset_i),
		.push_i  (rx_push),
		.entry_i (rx_entry),
		.pop_i   (fifo_pop),
		.head_o  (fifo_head),
		.count_o (fifo_count),
		.full_o  (fifo_full),
		.empty_o (fifo_empty)
	);

	kbd_wb_regs regs0 (
		.clock       (clock),
		.reset_i     (reset_i),
		.wb_req_i    (wb_req_i),
		.wb_rsp_o    (wb_rsp_o),
		.head_i      (fifo_head),
		.count_i     (fifo_count),
		.full_i      (fifo_full),
		.empty_i     (fifo_empty),
		.push_seen_i (rx_push),
		.pop_o       (fifo_pop),
		.enable_o    (kbd_enable)
	);

	// back-pressure, pull the clock low while disabled or full
	always_ff @(posedge clock) begin
		if (reset_i) begin
			clk_drive_q <= 1'b0;
		end else begin
			clk_drive_q <= !kbd_enable || fifo_full;
		end
	end

	assign ps2_clk_o    = 1'b0;	// open drain, only ever low
	assign ps2_clk_d_o  = clk_drive_q;
	assign ps2_data_o   = 1'b0;
	assign ps2_data_d_o = 1'b0;	// no host-to-device traffic

endmodule

//--- kbd_link.f
ps2_line_pkg.sv
kbd_bus_pkg.sv
ps2_frame_rx.sv
scan_fifo.sv
kbd_wb_regs.sv
kbd_core.sv
kbd_pad_top.sv
tb_kbd_pad_top.sv

//--- kbd_pad_top.sv
`timescale 1ns/100ps

module kbd_pad_top
	import kbd_bus_pkg::*;
(
	input  logic    clock,
	input  logic    reset_i,
	inout  wire     ps2_clk,
	inout  wire     ps2_data,
	input  wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o
);

	wire ps2_clk_in;
	wire ps2_clk_out;
	wire ps2_clk_en;
	wire ps2_data_in;
	wire ps2_data_out;
	wire ps2_data_en;

	// pads float unless the core asks to drive
	assign ps2_clk     = ps2_clk_en  ? ps2_clk_out  : 1'bz;
	assign ps2_data    = ps2_data_en ? ps2_data_out : 1'bz;
	assign ps2_clk_in  = ps2_clk;
	assign ps2_data_in = ps2_data;

	kbd_core core0 (
		.clock        (clock),
		.reset_i      (reset_i),
		.ps2_clk_i    (ps2_clk_in),
		.ps2_data_i   (ps2_data_in),
		.ps2_clk_o    (ps2_clk_out),
		.ps2_clk_d_o  (ps2_clk_en),
		.ps2_data_o   (ps2_data_out),
		.ps2_data_d_o (ps2_data_en),
		.wb_req_i     (wb_req_i),
		.wb_rsp_o     (wb_rsp_o)
	);

endmodule

//--- kbd_wb_regs.sv
`timescale 1ns/100ps

module kbd_wb_regs
	import kbd_bus_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset_i,
	input  wb_req_t               wb_req_i,
	output wb_rsp_t               wb_rsp_o,
	input  scan_entry_t           head_i,
	input  logic [FIFO_CNT_W-1:0] count_i,
	input  logic                  full_i,
	input  logic                  empty_i,
	input  logic                  push_seen_i,
	output logic                  pop_o,
	output logic                  enable_o
);

	reg_addr_t   addr;
	logic        req_go;
	logic        ack_q;
	logic        pop_q;
	logic        enable_q;
	logic        overflow_q;
	logic [15:0] rd_word;
	logic [15:0] rsp_dat_q;

	// stb is still up while ack is out, so mask that cycle
	assign req_go = wb_req_i.cyc && wb_req_i.stb && !ack_q;
	assign addr   = reg_addr_t'(wb_req_i.adr);

	always_comb begin
		case (addr)
			REG_DATA: begin
				if (empty_i) begin
					rd_word = 16'h0000;
				end else begin
					rd_word = {1'b1, 6'b000000, head_i.perr, head_i.code};
				end
			end
			REG_STATUS:  rd_word = {9'b0, overflow_q, full_i, empty_i, count_i};
			REG_CONTROL: rd_word = {15'b0, enable_q};
			default:     rd_word = 16'h0000;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			ack_q      <= 1'b0;
			pop_q      <= 1'b0;
			enable_q   <= 1'b0;	// keyboard held off until the host says so
			overflow_q <= 1'b0;
		end else begin
			ack_q <= req_go;
			pop_q <= req_go && !wb_req_i.we && addr == REG_DATA && !empty_i;

			if (req_go && wb_req_i.we && addr == REG_CONTROL) begin
				enable_q <= wb_req_i.dat[0];
			end

			// a dropped push wins over a clear in the same cycle
			if (push_seen_i && full_i) begin
				overflow_q <= 1'b1;
			end else if (req_go && wb_req_i.we && addr == REG_STATUS && wb_req_i.dat[6]) begin
				overflow_q <= 1'b0;
			end
		end
	end

	// head cannot move before the pop, only this block pops
	always_ff @(posedge clock) begin
		if (req_go) begin
			rsp_dat_q <= rd_word;
		end
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = rsp_dat_q;
	assign pop_o        = pop_q;	// lines up with ack
	assign enable_o     = enable_q;

	a_ack_single : assert property (@(posedge clock) disable iff (reset_i)
		wb_rsp_o.ack |=> !wb_rsp_o.ack);

endmodule

//--- ps2_frame_rx.sv
`timescale 1ns/100ps

module ps2_frame_rx
	import ps2_line_pkg::*;
	import kbd_bus_pkg::*;
(
	input  logic        clock,
	input  logic        reset_i,
	input  logic        ps2_clk_i,
	input  logic        ps2_data_i,
	input  logic        inhibit_i,
	output logic        push_o,
	output scan_entry_t entry_o
);

	logic [1:0]                            clk_sync;
	logic [1:0]                            data_sync;
	logic [PS2_FILTER_LEN-1:0]             clk_hist;
	logic                                  clk_filt;
	logic                                  fall;
	rx_state_t                             state;
	logic [2:0]                            bit_cnt;
	logic [$clog2(PS2_TIMEOUT_CYCLES)-1:0] stall_cnt;
	logic                                  stalled;
	logic [PS2_FRAME_BITS-1:0]             frame_q;
	logic [PS2_FRAME_BITS-1:0]             frame_next;
	logic                                  frame_ok;

	// both lines idle high, so the sync chain starts there
	always_ff @(posedge clock) begin
		if (reset_i) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_hist  <= '1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk_i};
			data_sync <= {data_sync[0], ps2_data_i};
			clk_hist  <= {clk_hist[PS2_FILTER_LEN-2:0], clk_sync[1]};
		end
	end

	// level only changes after a full run of equal samples
	always_ff @(posedge clock) begin
		if (reset_i) begin
			clk_filt <= 1'b1;
		end else if (&clk_hist) begin
			clk_filt <= 1'b1;
		end else if (~|clk_hist) begin
			clk_filt <= 1'b0;
		end
	end

	assign fall = clk_filt && ~|clk_hist;	// accepted high to low step

	// new bit enters at the top, start bit ends up in bit 0
	assign frame_next = {data_sync[1], frame_q[PS2_FRAME_BITS-1:1]};

	// start low, stop high, odd parity over data and parity bit
	assign frame_ok = !frame_next[0] && frame_next[PS2_FRAME_BITS-1] &&
		(^frame_next[PS2_FRAME_BITS-2:1]);

	assign stalled = (stall_cnt == $bits(stall_cnt)'(PS2_TIMEOUT_CYCLES - 1));

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state     <= RX_IDLE;
			bit_cnt   <= '0;
			stall_cnt <= '0;
			push_o    <= 1'b0;
		end else begin
			push_o <= 1'b0;

			if (fall || state == RX_IDLE || state == RX_INHIBIT) begin
				stall_cnt <= '0;
			end else begin
				stall_cnt <= stall_cnt + 1'b1;
			end

			case (state)
				RX_IDLE: begin
					bit_cnt <= '0;
					if (inhibit_i) begin
						state <= RX_INHIBIT;	// ignore our own pull-down
					end else if (fall) begin
						state <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (fall) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= RX_PARITY;
						end
					end
				end
				RX_PARITY: begin
					if (fall) begin
						state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (fall) begin
						push_o <= 1'b1;
						state  <= inhibit_i ? RX_INHIBIT : RX_IDLE;
					end
				end
				RX_INHIBIT: begin
					if (!inhibit_i) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase

			// inhibit lets a frame finish, a dead keyboard does not
			if (stalled && !fall) begin
				state <= RX_IDLE;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fall) begin
			frame_q <= frame_next;
		end
		if (fall && state == RX_STOP) begin
			entry_o.code <= frame_next[8:1];
			entry_o.perr <= !frame_ok;
		end
	end

	// one push per frame, frames are far apart
	a_push_single : assert property (@(posedge clock) disable iff (reset_i)
		push_o |=> !push_o);

endmodule

//--- ps2_line_pkg.sv
package ps2_line_pkg;

	// receiver FSM, one state per frame section
	typedef enum logic [2:0] {
		RX_IDLE,	// waiting for the start bit
		RX_DATA,	// eight data bits, lsb first
		RX_PARITY,
		RX_STOP,
		RX_INHIBIT	// clock line held low by the host side
	} rx_state_t;

	// start + 8 data + parity + stop
	localparam int PS2_FRAME_BITS = 11;

	// stall limit between falling edges inside a frame
	localparam int PS2_TIMEOUT_CYCLES = 4000;

	// equal samples needed before the clock level is taken
	localparam int PS2_FILTER_LEN = 4;

endpackage

//--- scan_fifo.sv
`timescale 1ns/100ps

module scan_fifo
	import kbd_bus_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset_i,
	input  logic                  push_i,
	input  scan_entry_t           entry_i,
	input  logic                  pop_i,
	output scan_entry_t           head_o,
	output logic [FIFO_CNT_W-1:0] count_o,
	output logic                  full_o,
	output logic                  empty_o
);

	scan_entry_t           mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count_q;
	logic                  do_push;
	logic                  do_pop;

	assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
	assign empty_o = (count_q == '0);
	assign count_o = count_q;

	assign do_push = push_i && !full_o;	// overflow is dropped here
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clock) begin
		if (reset_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth 8
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= entry_i;
		end
	end

	assign head_o = mem[rd_ptr];	// first-word fall-through

	a_count_bound : assert property (@(posedge clock) disable iff (reset_i)
		count_o <= FIFO_CNT_W'(FIFO_DEPTH));

endmodule

//--- tb_kbd_pad_top.sv
`timescale 1ns/100ps

module tb_kbd_pad_top
	import kbd_bus_pkg::*;
();

	// one table row: code, bad parity, random code, expected REG_DATA word
	typedef struct packed {
		logic [7:0]  code;
		logic        bad_par;
		logic        use_rand;
		logic [15:0] exp;
	} row_t;

	localparam int N_ROWS = 6;

	logic    clock;
	logic    reset_i;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic    kbd_clk_low;
	logic    kbd_data_low;
	row_t    rows [N_ROWS];
	wire     ps2_clk;
	wire     ps2_data;

	pullup (ps2_clk);
	pullup (ps2_data);

	// keyboard side is open drain as well
	assign ps2_clk  = kbd_clk_low  ? 1'b0 : 1'bz;
	assign ps2_data = kbd_data_low ? 1'b0 : 1'bz;

	kbd_pad_top dut0 (
		.clock    (clock),
		.reset_i  (reset_i),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// guard against a run that never ends
	initial begin
		repeat (100000) @(posedge clock);
		$display("Simulation ran out of time before the sequence completed");
		$display("Test failed");
		$fatal(1);
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic wb_access(input reg_addr_t adr, input logic we, input logic [15:0] wdat,
		output logic [15:0] rdat);
		int n;
		n = 0;
		@(posedge clock);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= we;
		wb_req.adr <= adr;
		wb_req.dat <= wdat;
		do begin
			@(negedge clock);
			n++;
		end while (wb_rsp.ack !== 1'b1 && n < 10);
		if (wb_rsp.ack !== 1'b1) begin
			abort_run("no Wishbone ack within 10 cycles");
		end else begin
			check_eq("ack_delay", 16'(n), 16'd2);	// ack one cycle after the request
			rdat = wb_rsp.dat;
			@(posedge clock);
			wb_req <= '0;	// cycle ends after ack
		end
	endtask

	task automatic wb_read(input reg_addr_t adr, output logic [15:0] dat);
		wb_access(adr, 1'b0, 16'h0000, dat);
	endtask

	task automatic wb_write(input reg_addr_t adr, input logic [15:0] dat);
		logic [15:0] unused;
		wb_access(adr, 1'b1, dat, unused);
	endtask

	// keyboard frame, gives up if the host keeps the clock low
	task automatic send_frame(input logic [7:0] code, input logic bad_par, input int limit,
		output logic sent);
		logic [10:0] bits;
		int n;
		bits = {1'b1, (~^code) ^ bad_par, code, 1'b0};
		n = 0;
		sent = 1'b0;
		@(negedge clock);
		while (ps2_clk !== 1'b1 && n < limit) begin
			@(negedge clock);
			n++;
		end
		if (ps2_clk === 1'b1) begin
			for (int i = 0; i < 11; i++) begin
				@(posedge clock);
				kbd_data_low <= !bits[i];	// data settles mid high phase
				repeat (5) @(posedge clock);
				kbd_clk_low <= 1'b1;
				repeat (10) @(posedge clock);
				kbd_clk_low <= 1'b0;
				repeat (4) @(posedge clock);
			end
			kbd_data_low <= 1'b0;
			sent = 1'b1;
		end
	endtask

	task automatic wait_count(input logic [3:0] want);
		logic [15:0] st;
		int n;
		n = 0;
		st = '0;
		do begin
			wb_read(REG_STATUS, st);
			n++;
		end while (st[3:0] != want && n < 200);
		if (st[3:0] != want) begin
			abort_run("FIFO count never reached the expected value");
		end
	endtask

	initial begin
		logic [15:0] rd;
		logic        sent;
		logic [31:0] rng;
		reset_i      = 1'b1;
		wb_req       = '0;
		kbd_clk_low  = 1'b0;
		kbd_data_low = 1'b0;
		rng          = 32'ha6e61317;
		rows[0] = {8'h1c, 1'b0, 1'b0, 16'h801c};
		rows[1] = {8'h32, 1'b0, 1'b0, 16'h8032};
		rows[2] = {8'h00, 1'b0, 1'b1, 16'h0000};
		rows[3] = {8'hf0, 1'b1, 1'b0, 16'h81f0};	// parity error keeps the code
		rows[4] = {8'h00, 1'b1, 1'b1, 16'h0000};
		rows[5] = {8'h5a, 1'b0, 1'b0, 16'h805a};
		for (int i = 0; i < N_ROWS; i++) begin
			if (rows[i].use_rand) begin
				rng = lcg_next(rng);
				rows[i].code = rng[23:16];
				rows[i].exp  = {1'b1, 6'b000000, rows[i].bad_par, rows[i].code};
			end
		end
		repeat (3) @(posedge clock);
		reset_i <= 1'b0;

		// disabled after reset, line held low
		repeat (3) @(negedge clock);
		check_eq("ps2_clk", {15'b0, ps2_clk}, 16'h0000);
		check_eq("ps2_data", {15'b0, ps2_data}, 16'h0001);	// data pad left free
		send_frame(8'h11, 1'b0, 200, sent);
		check_eq("kbd_sent", {15'b0, sent}, 16'h0000);
		wb_read(REG_STATUS, rd);
		check_eq("status", rd, 16'h0010);

		// table frames, read back in order
		wb_write(REG_CONTROL, 16'h0001);
		for (int i = 0; i < N_ROWS; i++) begin
			send_frame(rows[i].code, rows[i].bad_par, 2000, sent);
			check_eq("kbd_sent", {15'b0, sent}, 16'h0001);
		end
		wait_count(4'(N_ROWS));
		for (int i = 0; i < N_ROWS; i++) begin
			wb_read(REG_DATA, rd);
			check_eq("data", rd, rows[i].exp);
		end

		// fill the FIFO, line must go low
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			send_frame(8'h40 + 8'(i), 1'b0, 2000, sent);
			check_eq("kbd_sent", {15'b0, sent}, 16'h0001);
		end
		wait_count(4'(FIFO_DEPTH));
		wb_read(REG_STATUS, rd);
		check_eq("status", rd, 16'h0028);
		@(negedge clock);
		check_eq("ps2_clk", {15'b0, ps2_clk}, 16'h0000);
		check_eq("ps2_data", {15'b0, ps2_data}, 16'h0001);

		// pending frame goes out once one entry is popped
		fork
			send_frame(8'h77, 1'b0, 4000, sent);
			begin
				repeat (50) @(posedge clock);
				wb_read(REG_DATA, rd);
			end
		join
		check_eq("data", rd, 16'h8040);
		check_eq("kbd_sent", {15'b0, sent}, 16'h0001);
		wait_count(4'(FIFO_DEPTH));
		wb_read(REG_STATUS, rd);
		check_eq("status", rd, 16'h0028);	// nothing dropped, no overflow

		// overflow clear, then drain
		wb_write(REG_STATUS, 16'h0040);
		wb_read(REG_STATUS, rd);
		check_eq("status", rd, 16'h0028);
		for (int i = 1; i < FIFO_DEPTH; i++) begin
			wb_read(REG_DATA, rd);
			check_eq("data", rd, 16'h8040 + 16'(i));
		end
		wb_read(REG_DATA, rd);
		check_eq("data", rd, 16'h8077);
		wb_read(REG_DATA, rd);
		check_eq("data", rd, 16'h0000);	// empty read pops nothing
		wb_read(REG_STATUS, rd);
		check_eq("status", rd, 16'h0010);

		// disable again
		wb_write(REG_CONTROL, 16'h0000);
		repeat (3) @(negedge clock);
		check_eq("ps2_clk", {15'b0, ps2_clk}, 16'h0000);
		send_frame(8'h22, 1'b0, 200, sent);
		check_eq("kbd_sent", {15'b0, sent}, 16'h0000);
		wb_read(REG_STATUS, rd);
		check_eq("status", rd, 16'h0010);

		$display("Test passed");
		$finish;
	end

endmodule
